//--- verilog.f
+incdir+include
verilog/sifhPkg.sv
verilog/sifhConfig.sv
verilog/histRam.sv
verilog/sifhFsm.sv
verilog/peakFinder.sv
verilog/sifhTop.sv
testbench/sifhTb.sv

//--- runSim.sh
#!/bin/sh
# build and run the histogram testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module sifhTb -f verilog.f -o sifhSim
./obj_dir/sifhSim > sim.log 2>&1 || true
cat sim.log
if grep -q "Result: PASSED" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

//--- include/sifhTbTasks.svh
`ifndef sifhTbTasksSvh
`define sifhTbTasksSvh

// all tasks start and end on a falling edge
task automatic compareValue(input string what, input int actual, input int expected);
    if (actual != expected) begin
        $display("error at %0t ns: %s, got %0d, expected %0d", $time, what, actual, expected);
        $display("Result: FAILED");
        $fatal(1, "stopped at the first mismatch");
    end
endtask

// empty histogram and peak trackers
function automatic void clearModel();
    for (int p = 0; p < sifhPkg::pixelNum; p++) begin
        peakCount[p] = 0;
        peakBin[p] = 0;
        for (int b = 0; b < binNum; b++) begin
            modelCount[p][b] = 0;
        end
    end
endfunction

// dropped when disabled, no-photon marker, or bin past 63
function automatic void countModelHit(input int pix, input int ts);
    int bin;
    bin = ts >> modelShift;
    if (modelEnable && (ts != 1023) && (bin < binNum)) begin
        // saturating count
        if (modelCount[pix][bin] < 255) begin
            modelCount[pix][bin]++;
        end
        // only a new maximum moves the peak
        if (modelCount[pix][bin] > peakCount[pix]) begin
            peakCount[pix] = modelCount[pix][bin];
            peakBin[pix] = bin;
        end
    end
endfunction

task automatic writeConfig(input bit addr, input int value);
    cfgWe = 1'b1;
    cfgAddr = addr;
    cfgWdata = 8'(value);
    @(negedge clk);
    cfgWe = 1'b0;
    if (addr) begin
        modelShift = value & 3;
    end else begin
        modelEnable = (value & 1) != 0;
    end
endtask

// one cycle on the timestamp port, no model update
task automatic driveStamp(input int pix, input int ts);
    wrEn = 1'b1;
    pixel = sifhPkg::pixelT'(pix);
    data = sifhPkg::tsT'(ts);
    @(negedge clk);
    wrEn = 1'b0;
endtask

task automatic sendStamp(input int pix, input int ts);
    driveStamp(pix, ts);
    countModelHit(pix, ts);
endtask

task automatic readCount(input int addr, output int value);
    int waited;
    rdEn = 1'b1;
    rdAddr = sifhPkg::addrT'(addr);
    @(negedge clk);
    rdEn = 1'b0;
    waited = 0;
    while (!rdValid && (waited < 10)) begin
        @(negedge clk);
        waited++;
    end
    compareValue("readback latency in cycles", waited, 2);
    value = int'(rdCount);
endtask

// full RAM against the model
// address is pixel then bin
task automatic sweepReadback();
    int value;
    for (int addr = 0; addr < addrNum; addr++) begin
        readCount(addr, value);
        compareValue($sformatf("count of pixel %0d bin %0d", addr / binNum, addr % binNum),
                     value, modelCount[addr / binNum][addr % binNum]);
    end
endtask

// frame end and peak check, then stamps for as long as busy is high
task automatic runFrameEnd();
    int waited;
    int randWord;
    frameEnd = 1'b1;
    @(negedge clk);
    frameEnd = 1'b0;
    waited = 0;
    while (!peakValid && (waited < 10)) begin
        @(negedge clk);
        waited++;
        if (waited == 1) begin
            compareValue("busy one cycle after frame end", int'(busy), 1);
        end
    end
    compareValue("frame end to peakValid in cycles", waited, 3);
    for (int p = 0; p < sifhPkg::pixelNum; p++) begin
        compareValue($sformatf("peak bin of pixel %0d", p), int'(peakResult[p]), peakBin[p]);
    end
    // in-range stamps up to the last busy cycle are all lost
    waited = 0;
    while (busy && (waited < 400)) begin
        randWord = $random(seed);
        driveStamp((randWord >> 8) & 3, randWord & 255);
        waited++;
    end
    compareValue("busy after the clear sweep", int'(busy), 0);
    clearModel();
endtask

task automatic verifyResetState();
    compareValue("busy after reset", int'(busy), 0);
    compareValue("peakValid after reset", int'(peakValid), 0);
    compareValue("rdValid after reset", int'(rdValid), 0);
    // first sweep clears the unreset RAM
    runFrameEnd();
    // still disabled
    for (int i = 0; i < 40; i++) begin
        sendStamp(i % 4, i * 5);
    end
    sweepReadback();
endtask

task automatic accumulateRandom();
    int randWord;
    int ts;
    writeConfig(1'b0, 1);
    writeConfig(1'b1, 3);
    for (int i = 0; i < 400; i++) begin
        randWord = $random(seed);
        // upper half of the range falls past bin 63
        ts = randWord & 1023;
        if (((randWord >> 12) & 15) == 0) begin
            ts = 1023;
        end
        sendStamp((randWord >> 10) & 3, ts);
        // occasional gap
        if (((randWord >> 16) & 3) == 0) begin
            @(negedge clk);
        end
    end
    repeat (4) @(negedge clk);
    sweepReadback();
endtask

task automatic hammerOneBin();
    // pixel 2 bin 5 on every cycle
    for (int i = 0; i < 24; i++) begin
        sendStamp(2, 40 + (i % 8));
    end
    // bin 5 twice then bin 6
    for (int i = 0; i < 24; i++) begin
        sendStamp(2, ((i % 3) == 2) ? 48 : 41);
    end
    // same bin on two pixels
    for (int i = 0; i < 16; i++) begin
        sendStamp(i % 2, 40);
    end
    repeat (4) @(negedge clk);
    sweepReadback();
endtask

task automatic saturateBin();
    int value;
    // pixel 1 bin 20
    for (int i = 0; i < 300; i++) begin
        sendStamp(1, 160 + (i % 8));
    end
    repeat (4) @(negedge clk);
    readCount(binNum + 20, value);
    compareValue("saturated count of pixel 1 bin 20", value, 255);
endtask

task automatic closeFrame();
    runFrameEnd();
    sweepReadback();
endtask

task automatic retuneConfig();
    int randWord;
    writeConfig(1'b1, 0);
    // with no shift only stamps below 64 count
    for (int i = 0; i < 120; i++) begin
        randWord = $random(seed);
        sendStamp((randWord >> 8) & 3, randWord & 127);
    end
    repeat (4) @(negedge clk);
    sweepReadback();
    // counts freeze while disabled
    writeConfig(1'b0, 0);
    for (int i = 0; i < 60; i++) begin
        sendStamp(i % 4, i);
    end
    repeat (4) @(negedge clk);
    sweepReadback();
endtask

`endif

//--- testbench/sifhTb.sv
`timescale 1ns/1ps
`default_nettype none

module sifhTb;

    // roughly 6000 cycles of tests plus margin
    localparam int timeoutCycles = 20000;
    localparam sifhPkg::shiftT defaultShift = 2'd2;
    localparam int binNum = 2**sifhPkg::binBits;
    localparam int addrNum = 2**sifhPkg::addrBits;

    logic clk;
    logic rstN;
    logic cfgWe;
    logic cfgAddr;
    logic [7:0] cfgWdata;
    logic wrEn;
    sifhPkg::pixelT pixel;
    sifhPkg::tsT data;
    logic frameEnd;
    logic rdEn;
    sifhPkg::addrT rdAddr;
    logic rdValid;
    sifhPkg::countT rdCount;
    logic busy;
    logic peakValid;
    sifhPkg::peakArrT peakResult;

    // reference histogram, per pixel and bin
    int modelCount [sifhPkg::pixelNum][binNum];
    // running maximum and the bin that first reached it
    int peakCount [sifhPkg::pixelNum];
    int peakBin [sifhPkg::pixelNum];
    int modelShift;
    bit modelEnable;
    int seed;
    int cycleCount = 0;

    sifhTop #(
        .defaultBinShift(defaultShift)
    ) i_dut (
        .clk(clk),
        .rstN(rstN),
        .cfgWe(cfgWe),
        .cfgAddr(cfgAddr),
        .cfgWdata(cfgWdata),
        .wrEn(wrEn),
        .pixel(pixel),
        .data(data),
        .frameEnd(frameEnd),
        .rdEn(rdEn),
        .rdAddr(rdAddr),
        .rdValid(rdValid),
        .rdCount(rdCount),
        .busy(busy),
        .peakValid(peakValid),
        .peakResult(peakResult)
    );

    `include "sifhTbTasks.svh"

    // 10 ns clock
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // hang guard
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= timeoutCycles) begin
            $display("timeout: tests still running after %0d cycles", timeoutCycles);
            $display("Result: FAILED");
            $fatal(1, "simulation stopped by the cycle limit");
        end
    end

    initial begin
        seed = 32'h89e2_3917;
        rstN = 1'b0;
        cfgWe = 1'b0;
        cfgAddr = 1'b0;
        cfgWdata = 8'd0;
        wrEn = 1'b0;
        pixel = '0;
        data = '0;
        frameEnd = 1'b0;
        rdEn = 1'b0;
        rdAddr = '0;
        modelShift = int'(defaultShift);
        modelEnable = 1'b0;
        clearModel();
        repeat (16) @(negedge clk);
        rstN = 1'b1;
        @(negedge clk);
        verifyResetState();
        accumulateRandom();
        hammerOneBin();
        saturateBin();
        closeFrame();
        retuneConfig();
        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/sifhTop.sv
`timescale 1ns/1ps
`default_nettype none

module sifhTop #(
    parameter sifhPkg::shiftT defaultBinShift = 2'd2
) (
    input wire clk,
    input wire rstN,
    // host config writes
    input wire cfgWe,
    input wire cfgAddr,
    input wire [7:0] cfgWdata,
    // photon timestamps
    input wire wrEn,
    input wire sifhPkg::pixelT pixel,
    input wire sifhPkg::tsT data,
    input wire frameEnd,
    // host histogram readback
    input wire rdEn,
    input wire sifhPkg::addrT rdAddr,
    output wire rdValid,
    output wire sifhPkg::countT rdCount,
    output wire busy,
    output wire peakValid,
    output wire sifhPkg::peakArrT peakResult
);

    sifhPkg::cfgT cfg;
    sifhPkg::addrT waddr;
    sifhPkg::addrT raddr;
    sifhPkg::countT newCounts;
    sifhPkg::countT counts;
    sifhPkg::hitT hit;
    logic wEnable;
    logic rEnable;
    logic hitValid;
    logic publish;

    sifhConfig #(
        .defaultBinShift(defaultBinShift)
    ) i_config (
        .clk(clk),
        .rstN(rstN),
        .cfgWe(cfgWe),
        .cfgAddr(cfgAddr),
        .cfgWdata(cfgWdata),
        .cfg(cfg)
    );

    // read-modify-write control
    sifhFsm i_fsm (
        .clk(clk),
        .rstN(rstN),
        .cfg(cfg),
        .wrEn(wrEn),
        .pixel(pixel),
        .data(data),
        .frameEnd(frameEnd),
        .rdEn(rdEn),
        .rdAddr(rdAddr),
        .counts(counts),
        .waddr(waddr),
        .wEnable(wEnable),
        .newCounts(newCounts),
        .raddr(raddr),
        .rEnable(rEnable),
        .hit(hit),
        .hitValid(hitValid),
        .publish(publish),
        .busy(busy),
        .rdValid(rdValid),
        .rdCount(rdCount)
    );

    histRam i_ram (
        .clk(clk),
        .wEnable(wEnable),
        .waddr(waddr),
        .newCounts(newCounts),
        .rEnable(rEnable),
        .raddr(raddr),
        .counts(counts)
    );

    peakFinder i_peak (
        .clk(clk),
        .rstN(rstN),
        .hit(hit),
        .hitValid(hitValid),
        .publish(publish),
        .peakValid(peakValid),
        .peakResult(peakResult)
    );

endmodule

`default_nettype wire

//--- verilog/peakFinder.sv
`timescale 1ns/1ps
`default_nettype none

module peakFinder (
    input wire clk,
    input wire rstN,
    input wire sifhPkg::hitT hit,
    input wire hitValid,
    input wire publish,
    output logic peakValid,
    output sifhPkg::peakArrT peakResult
);

    // running maximum per pixel
    sifhPkg::countT bestCount [sifhPkg::pixelNum];
    // bin that first reached that maximum
    sifhPkg::peakArrT bestBin;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            peakValid <= 1'b0;
            bestBin <= '0;
            for (int i = 0; i < sifhPkg::pixelNum; i++) begin
                bestCount[i] <= '0;
            end
        end else begin
            peakValid <= publish;
            if (publish) begin
                // start the next frame from empty trackers
                // pixel without hits keeps bin 0
                bestBin <= '0;
                for (int i = 0; i < sifhPkg::pixelNum; i++) begin
                    bestCount[i] <= '0;
                end
            end else if (hitValid && (hit.count > bestCount[hit.pixel])) begin
                // strictly greater, so a tie keeps the earlier bin
                bestCount[hit.pixel] <= hit.count;
                bestBin[hit.pixel] <= hit.bin;
            end
        end
    end

    // result held until the next frame end
    always_ff @(posedge clk) begin
        if (publish) begin
            peakResult <= bestBin;
        end
    end

endmodule

`default_nettype wire

//--- verilog/sifhFsm.sv
`timescale 1ns/1ps
`default_nettype none

module sifhFsm (
    input wire clk,
    input wire rstN,
    input wire sifhPkg::cfgT cfg,
    input wire wrEn,
    input wire sifhPkg::pixelT pixel,
    input wire sifhPkg::tsT data,
    input wire frameEnd,
    input wire rdEn,
    input wire sifhPkg::addrT rdAddr,
    input wire sifhPkg::countT counts,
    output sifhPkg::addrT waddr,
    output logic wEnable,
    output sifhPkg::countT newCounts,
    output sifhPkg::addrT raddr,
    output logic rEnable,
    output sifhPkg::hitT hit,
    output logic hitValid,
    output logic publish,
    output logic busy,
    output logic rdValid,
    output sifhPkg::countT rdCount
);

    sifhPkg::fsmStateT state;
    logic drainStep;
    sifhPkg::addrT clearAddr;
    sifhPkg::tsT shifted;
    logic accept;
    logic rdServe;
    sifhPkg::addrT tsAddr;
    // stage 1, read in flight
    logic s1Inc;
    logic s1Rd;
    sifhPkg::addrT s1Addr;
    // last increment written, for forwarding
    logic lastValid;
    sifhPkg::addrT lastAddr;
    sifhPkg::countT lastCount;
    sifhPkg::countT base;
    sifhPkg::countT incCount;
    logic rdPend;
    sifhPkg::countT rdData;

    // timestamp to bin
    assign shifted = data >> cfg.binShift;
    assign tsAddr = {pixel, shifted[sifhPkg::binBits-1:0]};
    // all ones is the no-photon marker
    // shifted value must fit in 64 bins
    // nothing taken once the frame end edge has been seen
    assign accept = wrEn && cfg.enable && (state == sifhPkg::idle) && (data != '1) &&
                    (shifted[sifhPkg::tsBits-1:sifhPkg::binBits] == '0);
    // host read only in a free idle cycle
    assign rdServe = rdEn && !accept && !busy;

    // port b shared by increments and host reads
    assign raddr = accept ? tsAddr : rdAddr;
    assign rEnable = accept | rdServe;

    // RAM word is stale if the previous cycle wrote this address
    assign base = (lastValid && (lastAddr == s1Addr)) ? lastCount : counts;
    // saturate at 255
    assign incCount = (base == '1) ? base : base + 8'd1;

    // port a is the increment write-back or the clear sweep
    assign wEnable = s1Inc | (state == sifhPkg::clear);
    assign waddr = (state == sifhPkg::clear) ? clearAddr : s1Addr;
    assign newCounts = (state == sifhPkg::clear) ? '0 : incCount;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= sifhPkg::idle;
            drainStep <= 1'b0;
            clearAddr <= '0;
            busy <= 1'b0;
            publish <= 1'b0;
            s1Inc <= 1'b0;
            s1Rd <= 1'b0;
            lastValid <= 1'b0;
            hitValid <= 1'b0;
            rdPend <= 1'b0;
            rdValid <= 1'b0;
        end else begin
            publish <= 1'b0;
            s1Inc <= accept;
            s1Rd <= rdServe;
            lastValid <= s1Inc;
            hitValid <= s1Inc;
            // readback takes two cycles
            rdPend <= s1Rd;
            rdValid <= rdPend;
            case (state)
                sifhPkg::idle: begin
                    if (frameEnd) begin
                        state <= sifhPkg::drain;
                        drainStep <= 1'b0;
                    end
                end
                sifhPkg::drain: begin
                    // first step lets the last write-back land
                    if (!drainStep) begin
                        busy <= 1'b1;
                        drainStep <= 1'b1;
                    end else begin
                        // peak finder has the last hit by now
                        publish <= 1'b1;
                        clearAddr <= '0;
                        state <= sifhPkg::clear;
                    end
                end
                sifhPkg::clear: begin
                    clearAddr <= clearAddr + 1'b1;
                    if (clearAddr == '1) begin
                        state <= sifhPkg::idle;
                        busy <= 1'b0;
                    end
                end
                default: state <= sifhPkg::idle;
            endcase
        end
    end

    // datapath registers
    always_ff @(posedge clk) begin
        s1Addr <= raddr;
        lastAddr <= s1Addr;
        lastCount <= incCount;
        hit.pixel <= s1Addr[sifhPkg::addrBits-1:sifhPkg::binBits];
        hit.bin <= s1Addr[sifhPkg::binBits-1:0];
        hit.count <= incCount;
        // forwarded value serves host reads too
        rdData <= base;
        rdCount <= rdData;
    end

endmodule

`default_nettype wire

//--- verilog/histRam.sv
`timescale 1ns/1ps
`default_nettype none

module histRam (
    input wire clk,
    // port a, write only
    input wire wEnable,
    input wire sifhPkg::addrT waddr,
    input wire sifhPkg::countT newCounts,
    // port b, read only
    input wire rEnable,
    input wire sifhPkg::addrT raddr,
    output sifhPkg::countT counts
);

    // one word per pixel and bin
    sifhPkg::countT mem [2**sifhPkg::addrBits];

    always_ff @(posedge clk) begin
        if (wEnable) begin
            mem[waddr] <= newCounts;
        end
    end

    // registered read
    // same-address collision returns the old word
    always_ff @(posedge clk) begin
        if (rEnable) begin
            counts <= mem[raddr];
        end
    end

endmodule

`default_nettype wire

//--- verilog/sifhConfig.sv
`timescale 1ns/1ps
`default_nettype none

module sifhConfig #(
    parameter sifhPkg::shiftT defaultBinShift = 2'd2
) (
    input wire clk,
    input wire rstN,
    input wire cfgWe,
    // 0 selects enable, 1 selects binShift
    input wire cfgAddr,
    input wire [7:0] cfgWdata,
    output sifhPkg::cfgT cfg
);

    // write decode
    // each register takes only the low bits it needs
    always_ff @(posedge clk) begin
        if (!rstN) begin
            // histogramming off until the host enables it
            cfg.enable <= 1'b0;
            cfg.binShift <= defaultBinShift;
        end else if (cfgWe) begin
            if (cfgAddr) begin
                // coarser bins for a larger shift
                cfg.binShift <= cfgWdata[1:0];
            end else begin
                cfg.enable <= cfgWdata[0];
            end
        end
    end

    // new values reach the FSM one cycle after the strobe
    // no readback path here

endmodule

`default_nettype wire

//--- verilog/sifhPkg.sv
`default_nettype none

package sifhPkg;

    // raw timestamp width from the TDC
    localparam int tsBits = 10;
    // pixels sharing one histogram RAM
    localparam int pixelNum = 4;
    // 64 bins per pixel
    localparam int binBits = 6;
    // saturating 8-bit counts
    localparam int countBits = 8;
    // pixel index sits above the bin index
    localparam int addrBits = $clog2(pixelNum) + binBits;

    typedef logic [tsBits-1:0] tsT;
    typedef logic [$clog2(pixelNum)-1:0] pixelT;
    typedef logic [binBits-1:0] binT;
    typedef logic [countBits-1:0] countT;
    typedef logic [addrBits-1:0] addrT;
    typedef logic [1:0] shiftT;

    // register state seen by the histogram FSM
    typedef struct packed {
        logic enable;
        shiftT binShift;
    } cfgT;

    // one finished increment, handed to the peak finder
    typedef struct packed {
        pixelT pixel;
        binT bin;
        countT count;
    } hitT;

    // peak bin of every pixel, pixel 0 in the low bits
    typedef binT [pixelNum-1:0] peakArrT;

    typedef enum logic [1:0] {
        idle,
        drain,
        clear
    } fsmStateT;

endpackage

`default_nettype wire
